//--- src/chess_macros.svh
`ifndef CHESS_MACROS_SVH
`define CHESS_MACROS_SVH

// Board geometry
`define BOARD_ROWS       8
`define SQUARE_BITS      4
`define ROW_BITS         32

// Host bus byte address width
`define AXI_ADDR_BITS    16

// Word addresses (byte address / 4)
`define REG_CTRL         0
`define REG_STATE        2
`define REG_ROW0         8
`define REG_WHITE_OCC_LO 128
`define REG_WHITE_OCC_HI 129
`define REG_BLACK_OCC_LO 130
`define REG_BLACK_OCC_HI 131
`define REG_COUNTS       132
`define REG_STATUS       133
`define REG_LOADED_ROW0  172

`endif

//--- src/chess_pkg.sv
`include "chess_macros.svh"
`default_nettype none

package chess_pkg;

   localparam int COLS = `ROW_BITS / `SQUARE_BITS;
   localparam int SQUARES = `BOARD_ROWS * COLS;

   // Colour in the top bit and kind 0 for an empty square
   typedef struct packed {
      logic                      black;
      logic [`SQUARE_BITS-2:0]   kind;
   } piece_t;

   typedef piece_t [SQUARES-1:0] board_t; // Square 0 is low nibble of row 0

   typedef logic [6:0] count_t;

   typedef struct packed {
      board_t     board;
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef struct packed {
      position_t             pos;
      logic [SQUARES-1:0]    white_occ;
      logic [SQUARES-1:0]    black_occ;
   } occupancy_t;

   typedef struct packed {
      position_t             pos;
      logic [SQUARES-1:0]    white_occ;
      logic [SQUARES-1:0]    black_occ;
      count_t                white_count;
      count_t                black_count;
   } summary_t;

endpackage

`default_nettype wire

//--- src/axil_pkg.sv
`include "chess_macros.svh"
`default_nettype none

package axil_pkg;

   localparam int WORD_ADDR_BITS = `AXI_ADDR_BITS - 2;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

   // One joined write, address already in words
   typedef struct packed {
      word_addr_t  addr;
      logic [31:0] data;
   } wr_cmd_t;

   // Registered read response
   typedef struct packed {
      logic [1:0]  resp;
      logic [31:0] data;
   } rd_rsp_t;

endpackage

`default_nettype wire

//--- src/axil_write_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "chess_macros.svh"

module axil_write_capture (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [`AXI_ADDR_BITS-1:0]   awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [31:0]                 wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic                        bvalid,
   output logic [1:0]                  bresp,
   input  logic                        bready,
   output axil_pkg::wr_cmd_t           cmd,
   output logic                        cmd_valid
);

   logic                   addr_full;
   logic                   data_full;
   axil_pkg::word_addr_t   addr_q;
   logic [31:0]            data_q;
   logic                   aw_take;
   logic                   w_take;
   logic                   addr_have;
   logic                   data_have;

   assign awready = !addr_full && !bvalid; // Stall while response pending
   assign wready = !data_full && !bvalid;
   assign aw_take = awvalid && awready;
   assign w_take = wvalid && wready;
   assign addr_have = addr_full || aw_take;
   assign data_have = data_full || w_take;
   assign bresp = axil_pkg::RESP_OKAY;

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         addr_full <= 1'b0;
         data_full <= 1'b0;
         bvalid <= 1'b0;
         cmd_valid <= 1'b0;
      end
      else
      begin
         cmd_valid <= 1'b0;
         if (addr_have && data_have)
         begin
            addr_full <= 1'b0;
            data_full <= 1'b0;
            cmd_valid <= 1'b1; // Fire once both halves present
            bvalid <= 1'b1;
         end
         else
         begin
            addr_full <= addr_have;
            data_full <= data_have;
            if (bready)
               bvalid <= 1'b0;
         end
      end

   always_ff @(posedge clk)
   begin
      if (aw_take)
         addr_q <= awaddr[`AXI_ADDR_BITS-1:2];
      if (w_take)
         data_q <= wdata;
      if (addr_have && data_have)
      begin
         cmd.addr <= aw_take ? awaddr[`AXI_ADDR_BITS-1:2] : addr_q; // Bypass same-cycle beat
         cmd.data <= w_take ? wdata : data_q;
      end
   end

endmodule

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic      clk,
   input  logic      arst_n,
   input  payload_t  in_data,
   input  logic      in_valid,
   output payload_t  out_data,
   output logic      out_valid
);

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;

   // Payload only moves with a valid beat
   always_ff @(posedge clk)
      if (in_valid)
         out_data <= in_data;

endmodule

`default_nettype wire

//--- src/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "chess_macros.svh"

module ctrl_regs (
   input  logic                        clk,
   input  logic                        arst_n,
   input  axil_pkg::wr_cmd_t           cmd,
   input  logic                        cmd_valid,
   input  logic [`AXI_ADDR_BITS-1:0]   araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [31:0]                 rdata,
   output logic                        rvalid,
   output logic [1:0]                  rresp,
   input  logic                        rready,
   output chess_pkg::position_t        load_pos,
   output logic                        load,
   input  chess_pkg::summary_t         summary,
   input  logic                        summary_valid,
   output logic                        soft_reset
);

   chess_pkg::position_t   live;
   axil_pkg::rd_rsp_t      rsp;
   axil_pkg::word_addr_t   wr_off;
   axil_pkg::word_addr_t   rd_addr;
   axil_pkg::word_addr_t   row_off;
   axil_pkg::word_addr_t   loaded_off;
   logic [31:0]            rd_word;
   logic                   ar_take;
   logic                   ctrl_wr;

   assign ctrl_wr = cmd_valid && (cmd.addr == `REG_CTRL);
   assign wr_off = cmd.addr - axil_pkg::WORD_ADDR_BITS'(`REG_ROW0);

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         live <= '0;
         load <= 1'b0;
         soft_reset <= 1'b0;
      end
      else
      begin
         load <= 1'b0;
         soft_reset <= 1'b0;
         if (ctrl_wr)
         begin
            load <= cmd.data[0] && !cmd.data[31]; // Soft reset wins
            soft_reset <= cmd.data[31];
            if (cmd.data[31])
               live <= '0;
         end
         else if (cmd_valid && cmd.addr == `REG_STATE)
            {live.white_to_move, live.castle_mask, live.en_passant_col} <= cmd.data[8:0];
         else if (cmd_valid && wr_off < `BOARD_ROWS)
            live.board[chess_pkg::COLS*wr_off[2:0] +: chess_pkg::COLS] <= cmd.data;
      end

   // Snapshot handed to the summary pipeline
   always_ff @(posedge clk)
      if (ctrl_wr && cmd.data[0])
         load_pos <= live;

   assign rd_addr = araddr[`AXI_ADDR_BITS-1:2];
   assign row_off = rd_addr - axil_pkg::WORD_ADDR_BITS'(`REG_ROW0);
   assign loaded_off = rd_addr - axil_pkg::WORD_ADDR_BITS'(`REG_LOADED_ROW0);

   always_comb
   begin
      rd_word = '0;
      if (row_off < `BOARD_ROWS)
         rd_word = live.board[chess_pkg::COLS*row_off[2:0] +: chess_pkg::COLS];
      else if (loaded_off < `BOARD_ROWS)
         rd_word = summary.pos.board[chess_pkg::COLS*loaded_off[2:0] +: chess_pkg::COLS];
      else
         case (rd_addr)
            `REG_STATE:
               rd_word = {23'b0, live.white_to_move, live.castle_mask, live.en_passant_col};
            `REG_WHITE_OCC_LO: rd_word = summary.white_occ[31:0];
            `REG_WHITE_OCC_HI: rd_word = summary.white_occ[63:32];
            `REG_BLACK_OCC_LO: rd_word = summary.black_occ[31:0];
            `REG_BLACK_OCC_HI: rd_word = summary.black_occ[63:32];
            `REG_COUNTS:
               rd_word = {9'b0, summary.black_count, 9'b0, summary.white_count};
            `REG_STATUS:
               rd_word = {19'b0, summary.pos.white_to_move, summary.pos.castle_mask,
                          summary.pos.en_passant_col, 3'b0, summary_valid};
            default: rd_word = '0; // Unmapped and write-only
         endcase
   end

   assign arready = !rvalid || rready;
   assign ar_take = arvalid && arready;

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
         rvalid <= 1'b0;
      else if (ar_take)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;

   always_ff @(posedge clk)
      if (ar_take)
      begin
         rsp.data <= rd_word;
         rsp.resp <= axil_pkg::RESP_OKAY;
      end

   assign rdata = rsp.data;
   assign rresp = rsp.resp;

endmodule

`default_nettype wire

//--- src/position_summary.sv
`timescale 1ns/1ps
`default_nettype none
`include "chess_macros.svh"

module position_summary (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  soft_reset,
   input  logic                  load,
   input  chess_pkg::position_t  load_pos,
   output chess_pkg::summary_t   summary,
   output logic                  summary_valid
);

   chess_pkg::occupancy_t  occ_d;
   chess_pkg::occupancy_t  occ_q;
   logic                   occ_valid;
   chess_pkg::count_t      white_cnt;
   chess_pkg::count_t      black_cnt;

   // Stage 1 bitboards
   always_comb
   begin
      occ_d.pos = load_pos;
      occ_d.white_occ = '0;
      occ_d.black_occ = '0;
      for (int sq = 0; sq < chess_pkg::SQUARES; sq++)
         if (load_pos.board[sq].kind != '0)
         begin
            if (load_pos.board[sq].black)
               occ_d.black_occ[sq] = 1'b1;
            else
               occ_d.white_occ[sq] = 1'b1;
         end
   end

   pipe_reg #(
      .payload_t (chess_pkg::occupancy_t)
   ) u_occ_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_data   (occ_d),
      .in_valid  (load),
      .out_data  (occ_q),
      .out_valid (occ_valid)
   );

   // Stage 2 popcounts
   always_comb
   begin
      white_cnt = '0;
      black_cnt = '0;
      for (int sq = 0; sq < chess_pkg::SQUARES; sq++)
      begin
         white_cnt = white_cnt + chess_pkg::count_t'(occ_q.white_occ[sq]);
         black_cnt = black_cnt + chess_pkg::count_t'(occ_q.black_occ[sq]);
      end
   end

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         summary <= '0;
         summary_valid <= 1'b0;
      end
      else if (soft_reset)
      begin
         summary <= '0;
         summary_valid <= 1'b0;
      end
      else
      begin
         if (occ_valid)
         begin
            summary.pos <= occ_q.pos;
            summary.white_occ <= occ_q.white_occ;
            summary.black_occ <= occ_q.black_occ;
            summary.white_count <= white_cnt;
            summary.black_count <= black_cnt;
         end
         if (load)
            summary_valid <= 1'b0; // Newer load still in flight
         else if (occ_valid)
            summary_valid <= 1'b1;
      end

endmodule

`default_nettype wire

//--- src/chess_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "chess_macros.svh"

module chess_ctrl_top (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [`AXI_ADDR_BITS-1:0]   awaddr,
   input  logic [2:0]                  awprot,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [31:0]                 wdata,
   input  logic [3:0]                  wstrb,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`AXI_ADDR_BITS-1:0]   araddr,
   input  logic [2:0]                  arprot,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [31:0]                 rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready
);

   axil_pkg::wr_cmd_t      cap_cmd;
   logic                   cap_valid;
   axil_pkg::wr_cmd_t      reg_cmd;
   logic                   reg_valid;
   chess_pkg::position_t   load_pos;
   logic                   load;
   logic                   soft_reset;
   chess_pkg::summary_t    summary;
   logic                   summary_valid;

   axil_write_capture u_wr_cap (
      .clk       (clk),
      .arst_n    (arst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bvalid    (bvalid),
      .bresp     (bresp),
      .bready    (bready),
      .cmd       (cap_cmd),
      .cmd_valid (cap_valid)
   );

   pipe_reg #(
      .payload_t (axil_pkg::wr_cmd_t)
   ) u_cmd_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_data   (cap_cmd),
      .in_valid  (cap_valid),
      .out_data  (reg_cmd),
      .out_valid (reg_valid)
   );

   ctrl_regs u_regs (
      .clk           (clk),
      .arst_n        (arst_n),
      .cmd           (reg_cmd),
      .cmd_valid     (reg_valid),
      .araddr        (araddr),
      .arvalid       (arvalid),
      .arready       (arready),
      .rdata         (rdata),
      .rvalid        (rvalid),
      .rresp         (rresp),
      .rready        (rready),
      .load_pos      (load_pos),
      .load          (load),
      .summary       (summary),
      .summary_valid (summary_valid),
      .soft_reset    (soft_reset)
   );

   position_summary u_summary (
      .clk           (clk),
      .arst_n        (arst_n),
      .soft_reset    (soft_reset),
      .load          (load),
      .load_pos      (load_pos),
      .summary       (summary),
      .summary_valid (summary_valid)
   );

endmodule

`default_nettype wire

//--- verif/chess_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module chess_ctrl_props (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        bvalid,
   input  logic        bready,
   input  logic        rvalid,
   input  logic        rready,
   input  logic [31:0] rdata,
   input  logic        load,
   input  logic        soft_reset,
   input  logic        summary_valid
);

   // Write response held until the host takes it
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped without bready");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("read response changed before rready");

   a_load_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      load |=> !load)
      else $error("load strobe longer than one cycle");

   // Summary ready two cycles after an uncancelled load
   a_summary_latency: assert property (@(posedge clk) disable iff (!arst_n)
      load ##1 (!load && !soft_reset) |=> summary_valid)
      else $error("summary_valid not raised two cycles after load");

endmodule

`default_nettype wire

//--- verif/chess_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "chess_macros.svh"

module chess_ctrl_tb;

   typedef enum int { OP_WRITE, OP_READ, OP_LOAD, OP_SUMMARY, OP_LOADED, OP_RANDOM } op_t;

   typedef struct {
      string       name;
      op_t         op;
      int          addr;
      logic [31:0] data;
      logic [31:0] expected;
      int          skew; // Positive when aw leads w
   } test_row_t;

   logic clk = 1'b0;
   logic arst_n = 1'b0;
   logic [`AXI_ADDR_BITS-1:0] awaddr = '0;
   logic awvalid = 1'b0;
   logic [31:0] wdata = '0;
   logic wvalid = 1'b0;
   logic bready = 1'b0;
   logic [`AXI_ADDR_BITS-1:0] araddr = '0;
   logic arvalid = 1'b0;
   logic rready = 1'b0;
   logic awready;
   logic wready;
   logic bvalid;
   logic arready;
   logic rvalid;
   logic [1:0] bresp;
   logic [1:0] rresp;
   logic [31:0] rdata;

   test_row_t tests[$];
   logic [31:0] rng = 32'hacb4;
   logic [31:0] live_rows[8];
   logic [31:0] loaded_rows[8];
   logic [8:0] live_state;
   logic [8:0] loaded_state;
   int cycles = 0;
   int limit = 0;
   logic run_ended = 1'b0;

   always #4 clk = ~clk;

   chess_ctrl_top dut (
      .clk(clk), .arst_n(arst_n),
      .awaddr(awaddr), .awprot(3'b0), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(4'hf), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arprot(3'b0), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("Timeout after %0d cycles, DUT stopped responding", cycles);
         fail_run();
      end
   end

   // Run stopped early by a bound assertion
   final
      if (!run_ended)
         $display("Testbench failed");

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic fail_run();
      run_ended = 1'b1;
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic add(input string name, input op_t op, input int addr,
                      input logic [31:0] data, input logic [31:0] exp, input int skew);
      test_row_t row;
      row.name = name;
      row.op = op;
      row.addr = addr;
      row.data = data;
      row.expected = exp;
      row.skew = skew;
      tests.push_back(row);
   endtask

   task automatic bus_write(input int addr, input logic [31:0] data, input int skew);
      int aw_wait;
      int w_wait;
      int n;
      int hold;
      logic aw_done;
      logic w_done;
      logic aw_take;
      logic w_take;
      aw_wait = (skew < 0) ? -skew : 0;
      w_wait = (skew > 0) ? skew : 0;
      n = 0;
      aw_done = 1'b0;
      w_done = 1'b0;
      awaddr = `AXI_ADDR_BITS'(addr * 4);
      wdata = data;
      while (!(aw_done && w_done))
      begin
         if (!aw_done && n >= aw_wait)
            awvalid = 1'b1;
         if (!w_done && n >= w_wait)
            wvalid = 1'b1;
         @(negedge clk);
         aw_take = awvalid && awready;
         w_take = wvalid && wready;
         @(posedge clk);
         #1;
         if (aw_take)
         begin
            awvalid = 1'b0;
            aw_done = 1'b1;
         end
         if (w_take)
         begin
            wvalid = 1'b0;
            w_done = 1'b1;
         end
         n++;
      end
      hold = next_rand() % 4; // bready back-pressure
      repeat (hold)
      begin
         @(posedge clk);
         #1;
      end
      bready = 1'b1;
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      check_value("bresp", 32'(2'b00), 32'(bresp));
      check_value("awready in response", 32'd0, 32'(awready));
      check_value("wready in response", 32'd0, 32'(wready));
      @(posedge clk);
      #1 bready = 1'b0;
      @(negedge clk);
      check_value("single write response", 32'd0, 32'(bvalid));
      repeat (3) @(posedge clk); // Let the register update land
      #1;
   endtask

   task automatic bus_read(input int addr, output logic [31:0] data);
      int hold;
      logic taken;
      araddr = `AXI_ADDR_BITS'(addr * 4);
      arvalid = 1'b1;
      taken = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = arready;
         @(posedge clk);
         #1;
      end
      arvalid = 1'b0;
      hold = next_rand() % 4;
      repeat (hold)
      begin
         @(posedge clk);
         #1;
      end
      rready = 1'b1;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      data = rdata;
      check_value("rresp", 32'(2'b00), 32'(rresp));
      @(posedge clk);
      #1 rready = 1'b0;
      @(negedge clk);
      check_value("single read response", 32'd0, 32'(rvalid));
      @(posedge clk);
      #1;
   endtask

   // Shadow of host writes for the summary reference
   task automatic track_write(input int addr, input logic [31:0] data);
      if (addr >= `REG_ROW0 && addr < `REG_ROW0 + 8)
         live_rows[addr - `REG_ROW0] = data;
      else if (addr == `REG_STATE)
         live_state = data[8:0];
      else if (addr == `REG_CTRL && data[31])
      begin
         foreach (live_rows[i])
         begin
            live_rows[i] = '0;
            loaded_rows[i] = '0;
         end
         live_state = '0;
         loaded_state = '0;
      end
      else if (addr == `REG_CTRL && data[0])
      begin
         loaded_rows = live_rows;
         loaded_state = live_state;
      end
   endtask

   task automatic check_summary(input string name);
      logic [63:0] w_occ;
      logic [63:0] b_occ;
      logic [3:0] sq;
      int wc;
      int bc;
      logic [31:0] got;
      w_occ = '0;
      b_occ = '0;
      wc = 0;
      bc = 0;
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
         begin
            sq = loaded_rows[r][4*c +: 4];
            if (sq[2:0] != 3'd0 && sq[3])
            begin
               b_occ[r*8 + c] = 1'b1;
               bc++;
            end
            else if (sq[2:0] != 3'd0)
            begin
               w_occ[r*8 + c] = 1'b1;
               wc++;
            end
         end
      bus_read(`REG_WHITE_OCC_LO, got);
      check_value({name, " white lo"}, w_occ[31:0], got);
      bus_read(`REG_WHITE_OCC_HI, got);
      check_value({name, " white hi"}, w_occ[63:32], got);
      bus_read(`REG_BLACK_OCC_LO, got);
      check_value({name, " black lo"}, b_occ[31:0], got);
      bus_read(`REG_BLACK_OCC_HI, got);
      check_value({name, " black hi"}, b_occ[63:32], got);
      bus_read(`REG_COUNTS, got);
      check_value({name, " counts"}, (32'(bc) << 16) | 32'(wc), got);
      bus_read(`REG_STATUS, got);
      check_value({name, " status"}, (32'(loaded_state) << 4) | 32'd1, got);
   endtask

   task automatic load_and_wait();
      logic [31:0] got;
      int polls;
      bus_write(`REG_CTRL, 32'd1, 0);
      track_write(`REG_CTRL, 32'd1);
      polls = 0;
      got = '0;
      while (!got[0])
      begin
         bus_read(`REG_STATUS, got);
         polls++;
         if (polls > 10)
         begin
            $display("summary_valid never came up after a load");
            fail_run();
         end
      end
   endtask

   task automatic run_row(input test_row_t t);
      logic [31:0] got;
      case (t.op)
         OP_WRITE:
         begin
            bus_write(t.addr, t.data, t.skew);
            track_write(t.addr, t.data);
         end
         OP_READ:
         begin
            bus_read(t.addr, got);
            check_value(t.name, t.expected, got);
         end
         OP_LOAD: load_and_wait();
         OP_SUMMARY: check_summary(t.name);
         OP_LOADED:
            for (int r = 0; r < 8; r++)
            begin
               bus_read(`REG_LOADED_ROW0 + r, got);
               check_value(t.name, loaded_rows[r], got);
            end
         OP_RANDOM:
            for (int r = 0; r < 8; r++)
            begin
               got = next_rand();
               bus_write(`REG_ROW0 + r, got, r % 3 - 1);
               track_write(`REG_ROW0 + r, got);
            end
         default: ;
      endcase
   endtask

   task automatic build_table();
      add("reset ctrl", OP_READ, `REG_CTRL, 0, 0, 0);
      add("reset state", OP_READ, `REG_STATE, 0, 0, 0);
      add("reset row0", OP_READ, `REG_ROW0, 0, 0, 0);
      add("reset row7", OP_READ, `REG_ROW0 + 7, 0, 0, 0);
      add("reset white lo", OP_READ, `REG_WHITE_OCC_LO, 0, 0, 0);
      add("reset white hi", OP_READ, `REG_WHITE_OCC_HI, 0, 0, 0);
      add("reset black lo", OP_READ, `REG_BLACK_OCC_LO, 0, 0, 0);
      add("reset black hi", OP_READ, `REG_BLACK_OCC_HI, 0, 0, 0);
      add("reset counts", OP_READ, `REG_COUNTS, 0, 0, 0);
      add("reset status", OP_READ, `REG_STATUS, 0, 0, 0);
      add("reset loaded row0", OP_READ, `REG_LOADED_ROW0, 0, 0, 0);
      add("white back rank", OP_WRITE, `REG_ROW0, 32'h42365324, 0, 0);
      add("white pawns", OP_WRITE, `REG_ROW0 + 1, 32'h11111111, 0, 2);
      add("black pawns", OP_WRITE, `REG_ROW0 + 6, 32'h99999999, 0, -2);
      add("black back rank", OP_WRITE, `REG_ROW0 + 7, 32'hcabedbac, 0, 1);
      add("state", OP_WRITE, `REG_STATE, 32'h1f8, 0, -1);
      add("row0 back", OP_READ, `REG_ROW0, 0, 32'h42365324, 0);
      add("row1 back", OP_READ, `REG_ROW0 + 1, 0, 32'h11111111, 0);
      add("row6 back", OP_READ, `REG_ROW0 + 6, 0, 32'h99999999, 0);
      add("row7 back", OP_READ, `REG_ROW0 + 7, 0, 32'hcabedbac, 0);
      add("state back", OP_READ, `REG_STATE, 0, 32'h1f8, 0);
      add("opening load", OP_LOAD, 0, 0, 0, 0);
      add("opening summary", OP_SUMMARY, 0, 0, 0, 0);
      add("opening loaded rows", OP_LOADED, 0, 0, 0, 0);
      add("rewrite row0", OP_WRITE, `REG_ROW0, 32'h0, 0, 0);
      add("live row0 cleared", OP_READ, `REG_ROW0, 0, 0, 0);
      add("loaded rows kept", OP_LOADED, 0, 0, 0, 0);
      for (int i = 0; i < 3; i++)
      begin
         add("random board", OP_RANDOM, 0, 0, 0, 0);
         add("random load", OP_LOAD, 0, 0, 0, 0);
         add("random summary", OP_SUMMARY, 0, 0, 0, 0);
         add("random loaded rows", OP_LOADED, 0, 0, 0, 0);
      end
      add("soft reset", OP_WRITE, `REG_CTRL, 32'h80000000, 0, 0);
      add("soft row1", OP_READ, `REG_ROW0 + 1, 0, 0, 0);
      add("soft state", OP_READ, `REG_STATE, 0, 0, 0);
      add("soft status", OP_READ, `REG_STATUS, 0, 0, 0);
      add("soft white lo", OP_READ, `REG_WHITE_OCC_LO, 0, 0, 0);
      add("soft loaded row0", OP_READ, `REG_LOADED_ROW0, 0, 0, 0);
      add("unmapped", OP_READ, 200, 0, 0, 0);
   endtask

   initial
   begin
      foreach (live_rows[i])
      begin
         live_rows[i] = '0;
         loaded_rows[i] = '0;
      end
      live_state = '0;
      loaded_state = '0;
      build_table();
      limit = tests.size() * 40;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;
      foreach (tests[i])
         run_row(tests[i]);
      run_ended = 1'b1;
      $display("Testbench passed");
      $finish;
   end

endmodule

bind chess_ctrl_top chess_ctrl_props u_props (
   .clk           (clk),
   .arst_n        (arst_n),
   .bvalid        (bvalid),
   .bready        (bready),
   .rvalid        (rvalid),
   .rready        (rready),
   .rdata         (rdata),
   .load          (load),
   .soft_reset    (soft_reset),
   .summary_valid (summary_valid)
);

`default_nettype wire

//--- build.f
+incdir+src
src/chess_pkg.sv
src/axil_pkg.sv
src/axil_write_capture.sv
src/pipe_reg.sv
src/ctrl_regs.sv
src/position_summary.sv
src/chess_ctrl_top.sv
verif/chess_ctrl_props.sv
verif/chess_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= chess_ctrl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Testbench failed" $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
